// File: filelist.f
+incdir+design
design/aes_pkg.sv
design/aes_key_round.sv
design/aes_key_schedule.sv
design/aes_inv_round.sv
design/aes_dec_core.sv
design/aes_dec_top.sv
tests/tb_aes_dec.sv

// File: Bender.yml
package:
  name: aes_dec

sources:
  - include_dirs:
      - design
    files:
      - design/aes_pkg.sv
      - design/aes_key_round.sv
      - design/aes_key_schedule.sv
      - design/aes_inv_round.sv
      - design/aes_dec_core.sv
      - design/aes_dec_top.sv
      - target: test
        include_dirs:
          - design
        files:
          - tests/tb_aes_dec.sv

// File: tests/tb_aes_dec.sv
`include "aes_config.svh"

module tb_aes_dec
  import aes_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_VECTORS = 3;
  localparam int RESET_CYCLES = 10;
  localparam int LATENCY = `AES_DEC_LATENCY;
  localparam int HOLD_CYCLES = 20;
  localparam int DONE_WAIT_LIMIT = 2 * LATENCY;
  // Budget of ten operations with idle holds, plus reset and gaps
  localparam int MAX_CYCLES = RESET_CYCLES + 10 * (LATENCY + HOLD_CYCLES) + 70;

  typedef struct packed {
    aes_state_t key;
    aes_state_t cipher;
    aes_state_t plain;
  } vector_t;

  // Standard AES-128 vectors
  localparam vector_t VECTORS [NUM_VECTORS] = '{
    '{128'h000102030405060708090a0b0c0d0e0f,
      128'h69c4e0d86a7b0430d8cdb78070b4c55a,
      128'h00112233445566778899aabbccddeeff},
    '{128'h2b7e151628aed2a6abf7158809cf4f3c,
      128'h3925841d02dc09fbdc118597196a0b32,
      128'h3243f6a8885a308d313198a2e0370734},
    '{128'h00000000000000000000000000000000,
      128'h66e94bd4ef8a2c3b884cfa59ca342b2e,
      128'h00000000000000000000000000000000}
  };

  logic       clk;
  logic       reset;
  logic       start;
  aes_state_t key;
  aes_state_t cipher_text;
  aes_state_t plain_text;
  logic       busy;
  logic       done;

  integer seed = 3;
  int     error_count = 0;
  int     op_count = 0;
  int     cycle_cnt = 0;

  aes_dec_top u_aes_dec_top (
    .clk         (clk),
    .reset       (reset),
    .start       (start),
    .key         (key),
    .cipher_text (cipher_text),
    .plain_text  (plain_text),
    .busy        (busy),
    .done        (done)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, the tests did not finish", cycle_cnt);
      $display("** FAIL **");
      $finish;
    end
  end

  // ====================
  // Helpers
  // ====================

  function automatic aes_state_t random_block();
    return {$random(seed), $random(seed), $random(seed), $random(seed)};
  endfunction

  task automatic report_error(input string msg);
    error_count++;
    $display("Error at %0d ns: %s", $time, msg);
  endtask

  // Inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic start_op(input aes_state_t k, input aes_state_t c);
    start = 1'b1;
    key = k;
    cipher_text = c;
    op_count++;
  endtask

  // Garbage on key and cipher_text after the start, and a start at inject_at
  task automatic await_done(input aes_state_t expected, input int inject_at);
    int   n;
    logic seen;
    n = 0;
    seen = 1'b0;
    while (!seen && n < DONE_WAIT_LIMIT) begin
      next_cycle();
      n++;
      if (done) begin
        seen = 1'b1;
      end else if (!busy) begin
        report_error($sformatf("busy low %0d cycles after start", n));
      end
      start = (n == inject_at);
      key = random_block();
      cipher_text = random_block();
    end
    if (!seen) begin
      error_count++;
      $display("No done pulse within %0d cycles of a start", DONE_WAIT_LIMIT);
    end else begin
      if (n != LATENCY) begin
        report_error($sformatf("done after %0d cycles, expected %0d", n, LATENCY));
      end
      if (busy) begin
        report_error("busy still high in the done cycle");
      end
      if (plain_text !== expected) begin
        report_error($sformatf("plain_text %h, expected %h", plain_text, expected));
      end
    end
  endtask

  task automatic hold_idle(input int cycles, input aes_state_t expected);
    for (int i = 0; i < cycles; i++) begin
      next_cycle();
      start = 1'b0;
      key = random_block();
      cipher_text = random_block();
      if (done) begin
        report_error($sformatf("unexpected done %0d cycles into idle", i + 1));
      end
      if (busy) begin
        report_error($sformatf("busy high %0d cycles into idle", i + 1));
      end
      if (plain_text !== expected) begin
        report_error($sformatf("plain_text %h while idle, expected %h", plain_text, expected));
      end
    end
  endtask

  // ====================
  // Test sequence
  // ====================

  initial begin
    reset = 1'b1;
    start = 1'b0;
    key = '0;
    cipher_text = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset = 1'b0;
    if (busy !== 1'b0 || done !== 1'b0 || plain_text !== '0) begin
      report_error("outputs not cleared by reset");
    end

    // Each vector alone, then the result held while idle
    for (int i = 0; i < NUM_VECTORS; i++) begin
      start_op(VECTORS[i].key, VECTORS[i].cipher);
      await_done(VECTORS[i].plain, 0);
      hold_idle(HOLD_CYCLES, VECTORS[i].plain);
    end

    // Start while busy must be ignored
    start_op(VECTORS[1].key, VECTORS[1].cipher);
    await_done(VECTORS[1].plain, 4);
    hold_idle(HOLD_CYCLES, VECTORS[1].plain);

    // Back to back, the next start in the done cycle
    // Ends on a nonzero result ahead of the reset test
    for (int i = NUM_VECTORS - 1; i >= 0; i--) begin
      start_op(VECTORS[i].key, VECTORS[i].cipher);
      await_done(VECTORS[i].plain, 0);
    end
    hold_idle(HOLD_CYCLES, VECTORS[0].plain);

    // Reset in the middle of an operation
    start_op(VECTORS[1].key, VECTORS[1].cipher);
    next_cycle();
    start = 1'b0;
    repeat (4) next_cycle();
    reset = 1'b1;
    repeat (2) next_cycle();
    if (busy !== 1'b0 || done !== 1'b0) begin
      report_error("busy or done high after mid-operation reset");
    end
    if (plain_text !== '0) begin
      report_error($sformatf("plain_text %h after reset, expected zero", plain_text));
    end
    reset = 1'b0;
    hold_idle(HOLD_CYCLES, '0);
    start_op(VECTORS[0].key, VECTORS[0].cipher);
    await_done(VECTORS[0].plain, 0);
    hold_idle(2, VECTORS[0].plain);

    $display("Operations: %0d, errors: %0d", op_count, error_count);
    if (error_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: design/aes_dec_top.sv
`include "aes_config.svh"

module aes_dec_top
  import aes_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       start,
  input  aes_state_t key,
  input  aes_state_t cipher_text,
  output aes_state_t plain_text,
  output logic       busy,
  output logic       done
);

  logic            key_load;
  logic            final_round;
  aes_round_keys_t round_keys;
  aes_state_t      round_state;
  aes_state_t      round_key;
  aes_state_t      next_state;

  aes_key_schedule u_key_schedule (
    .clk        (clk),
    .reset      (reset),
    .key_load   (key_load),
    .key        (key),
    .round_keys (round_keys)
  );

  aes_inv_round u_inv_round (
    .round_state (round_state),
    .round_key   (round_key),
    .final_round (final_round),
    .next_state  (next_state)
  );

  aes_dec_core u_dec_core (
    .clk         (clk),
    .reset       (reset),
    .start       (start),
    .cipher_text (cipher_text),
    .round_keys  (round_keys),
    .next_state  (next_state),
    .key_load    (key_load),
    .round_state (round_state),
    .round_key   (round_key),
    .final_round (final_round),
    .plain_text  (plain_text),
    .busy        (busy),
    .done        (done)
  );

endmodule

// File: design/aes_dec_core.sv
`include "aes_config.svh"

module aes_dec_core
  import aes_pkg::*;
(
  input  logic            clk,
  input  logic            reset,
  input  logic            start,
  input  aes_state_t      cipher_text,
  input  aes_round_keys_t round_keys,
  input  aes_state_t      next_state,
  output logic            key_load,
  output aes_state_t      round_state,
  output aes_state_t      round_key,
  output logic            final_round,
  output aes_state_t      plain_text,
  output logic            busy,
  output logic            done
);

  aes_dec_fsm_t fsm_q;
  aes_round_t   round_cnt;
  aes_state_t   state_q;
  logic         accept;

  // Starts while busy are dropped
  assign accept = start && (fsm_q == DEC_IDLE);
  assign key_load = accept;
  assign busy = (fsm_q != DEC_IDLE);

  // ====================
  // Control
  // ====================

  always_ff @(posedge clk) begin
    if (reset) begin
      fsm_q <= DEC_IDLE;
      round_cnt <= '0;
      plain_text <= '0;
      done <= 1'b0;
    end else begin
      done <= 1'b0;
      case (fsm_q)
        DEC_IDLE: begin
          if (accept) begin
            fsm_q <= DEC_WHITEN;
            round_cnt <= aes_round_t'(`AES_NUM_ROUNDS);
          end
        end
        DEC_WHITEN: begin
          fsm_q <= DEC_ROUND;
          round_cnt <= round_cnt - 1'b1;
        end
        DEC_ROUND: begin
          if (final_round) begin
            fsm_q <= DEC_IDLE;
            plain_text <= next_state;
            done <= 1'b1;
          end else begin
            round_cnt <= round_cnt - 1'b1;
          end
        end
        default: fsm_q <= DEC_IDLE;
      endcase
    end
  end

  // ====================
  // Datapath
  // ====================

  always_ff @(posedge clk) begin
    case (fsm_q)
      DEC_IDLE: begin
        if (accept) begin
          state_q <= cipher_text;
        end
      end
      // Counter sits at 10 here, so round_key is the last round key
      DEC_WHITEN: state_q <= state_q ^ round_key;
      DEC_ROUND:  state_q <= next_state;
      default:    state_q <= state_q;
    endcase
  end

  assign round_state = state_q;
  assign round_key = round_keys[round_cnt];
  assign final_round = (fsm_q == DEC_ROUND) && (round_cnt == '0);

  done_single_pulse: assert property (
    @(posedge clk) disable iff (reset)
    done |=> !done
  ) else $error("done high for two consecutive cycles");

  busy_done_exclusive: assert property (
    @(posedge clk) disable iff (reset)
    !(busy && done)
  ) else $error("busy and done high together");

  round_cnt_range: assert property (
    @(posedge clk) disable iff (reset)
    (fsm_q == DEC_ROUND) |-> (round_cnt < aes_round_t'(`AES_NUM_ROUNDS))
  ) else $error("round counter above 9 in round state");

  // Fixed latency from an accepted start to done
  start_to_done: assert property (
    @(posedge clk) disable iff (reset)
    accept |-> ##(`AES_DEC_LATENCY) done
  ) else $error("done missing %0d cycles after start", `AES_DEC_LATENCY);

endmodule

// File: design/aes_inv_round.sv
`include "aes_config.svh"

module aes_inv_round
  import aes_pkg::*;
(
  input  aes_state_t round_state,
  input  aes_state_t round_key,
  input  logic       final_round,
  output aes_state_t next_state
);

  localparam int NUM_BYTES = `AES_BLOCK_W / `AES_BYTE_W;
  localparam int NUM_COLS = `AES_BLOCK_W / `AES_WORD_W;
  localparam int NUM_ROWS = `AES_WORD_W / `AES_BYTE_W;

  aes_state_t shifted;
  aes_state_t subbed;
  aes_state_t keyed;
  aes_state_t mixed;

  // Byte 0 is the top byte, state is stored column by column
  function automatic int byte_lsb(input int idx);
    return (NUM_BYTES - 1 - idx) * `AES_BYTE_W;
  endfunction

  // InvShiftRows then InvSubBytes then AddRoundKey
  always_comb begin
    for (int c = 0; c < NUM_COLS; c++) begin
      for (int r = 0; r < NUM_ROWS; r++) begin
        // Row r rotates right by r columns
        shifted[byte_lsb(NUM_ROWS*c + r) +: `AES_BYTE_W] =
          round_state[byte_lsb(NUM_ROWS*((c - r + NUM_COLS) % NUM_COLS) + r) +: `AES_BYTE_W];
      end
    end
    for (int i = 0; i < NUM_BYTES; i++) begin
      subbed[byte_lsb(i) +: `AES_BYTE_W] = aes_inv_sbox(shifted[byte_lsb(i) +: `AES_BYTE_W]);
    end
    keyed = subbed ^ round_key;
  end

  // ====================
  // InvMixColumns
  // ====================

  always_comb begin
    aes_byte_t col [NUM_ROWS];
    for (int c = 0; c < NUM_COLS; c++) begin
      for (int r = 0; r < NUM_ROWS; r++) begin
        col[r] = keyed[byte_lsb(NUM_ROWS*c + r) +: `AES_BYTE_W];
      end
      // Circulant matrix with rows rotating 0e 0b 0d 09
      for (int r = 0; r < NUM_ROWS; r++) begin
        mixed[byte_lsb(NUM_ROWS*c + r) +: `AES_BYTE_W] =
          aes_gmul14(col[r]) ^
          aes_gmul11(col[(r + 1) % NUM_ROWS]) ^
          aes_gmul13(col[(r + 2) % NUM_ROWS]) ^
          aes_gmul9(col[(r + 3) % NUM_ROWS]);
      end
    end
  end

  // Last round has no InvMixColumns
  assign next_state = final_round ? keyed : mixed;

endmodule

// File: design/aes_key_schedule.sv
`include "aes_config.svh"

module aes_key_schedule
  import aes_pkg::*;
(
  input  logic            clk,
  input  logic            reset,
  input  logic            key_load,
  input  aes_state_t      key,
  output aes_round_keys_t round_keys
);

  aes_state_t key_q;

  // Cipher key, held for the whole operation
  always_ff @(posedge clk) begin
    if (reset) begin
      key_q <= '0;
    end else if (key_load) begin
      key_q <= key;
    end
  end

  assign round_keys[0] = key_q;

  // ====================
  // Expansion chain
  // ====================

  for (genvar r = 1; r <= `AES_NUM_ROUNDS; r++) begin : g_key_round
    aes_key_round #(
      .ROUND_NUM (aes_round_t'(r))
    ) u_key_round (
      .prev_key (round_keys[r-1]),
      .next_key (round_keys[r])
    );
  end

  // The core only loads once per accepted start, and whitening follows
  key_load_single_cycle: assert property (
    @(posedge clk) disable iff (reset)
    key_load |=> !key_load
  ) else $error("key_load asserted in two consecutive cycles");

endmodule

// File: design/aes_key_round.sv
`include "aes_config.svh"

module aes_key_round
  import aes_pkg::*;
#(
  parameter aes_round_t ROUND_NUM = 4'd1
) (
  input  aes_state_t prev_key,
  output aes_state_t next_key
);

  localparam int NUM_WORDS = `AES_KEY_W / `AES_WORD_W;
  localparam int WORD_BYTES = `AES_WORD_W / `AES_BYTE_W;

  if (ROUND_NUM < 1 || ROUND_NUM > `AES_NUM_ROUNDS) begin : g_bad_round
    $error("aes_key_round: ROUND_NUM %0d out of range", ROUND_NUM);
  end

  aes_word_t last_word;
  aes_word_t rot_word;
  aes_word_t sub_word;
  aes_word_t chain_word;

  always_comb begin
    last_word = prev_key[`AES_WORD_W-1:0];
    // RotWord moves the top byte to the bottom
    rot_word = {last_word[`AES_WORD_W-`AES_BYTE_W-1:0],
                last_word[`AES_WORD_W-1 -: `AES_BYTE_W]};
    for (int b = 0; b < WORD_BYTES; b++) begin
      sub_word[b*`AES_BYTE_W +: `AES_BYTE_W] = aes_sbox(rot_word[b*`AES_BYTE_W +: `AES_BYTE_W]);
    end
    chain_word = sub_word ^ {aes_rcon(ROUND_NUM), {(`AES_WORD_W-`AES_BYTE_W){1'b0}}};

    // Each new word is the old word XOR the new word before it
    for (int w = 0; w < NUM_WORDS; w++) begin
      chain_word = chain_word ^ prev_key[`AES_KEY_W-1 - w*`AES_WORD_W -: `AES_WORD_W];
      next_key[`AES_KEY_W-1 - w*`AES_WORD_W -: `AES_WORD_W] = chain_word;
    end
  end

endmodule

// File: design/aes_pkg.sv
`include "aes_config.svh"

package aes_pkg;

  // ====================
  // Types
  // ====================

  typedef logic [`AES_BLOCK_W-1:0] aes_state_t;
  typedef logic [`AES_WORD_W-1:0] aes_word_t;
  typedef logic [`AES_BYTE_W-1:0] aes_byte_t;
  typedef logic [$clog2(`AES_NUM_ROUNDS+1)-1:0] aes_round_t;

  // Round key n at index n
  typedef aes_state_t aes_round_keys_t [`AES_NUM_ROUNDS+1];

  typedef enum logic [1:0] {
    DEC_IDLE,
    DEC_WHITEN,
    DEC_ROUND
  } aes_dec_fsm_t;

  // ====================
  // S-box tables
  // ====================

  // Entry 0 is the leftmost byte of each table
  localparam logic [0:255][`AES_BYTE_W-1:0] AES_SBOX = {
    128'h637c777bf26b6fc53001672bfed7ab76,
    128'hca82c97dfa5947f0add4a2af9ca472c0,
    128'hb7fd9326363ff7cc34a5e5f171d83115,
    128'h04c723c31896059a071280e2eb27b275,
    128'h09832c1a1b6e5aa0523bd6b329e32f84,
    128'h53d100ed20fcb15b6acbbe394a4c58cf,
    128'hd0efaafb434d338545f9027f503c9fa8,
    128'h51a3408f929d38f5bcb6da2110fff3d2,
    128'hcd0c13ec5f974417c4a77e3d645d1973,
    128'h60814fdc222a908846eeb814de5e0bdb,
    128'he0323a0a4906245cc2d3ac629195e479,
    128'he7c8376d8dd54ea96c56f4ea657aae08,
    128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
    128'h703eb5664803f60e613557b986c11d9e,
    128'he1f8981169d98e949b1e87e9ce5528df,
    128'h8ca1890dbfe6426841992d0fb054bb16
  };

  localparam logic [0:255][`AES_BYTE_W-1:0] AES_INV_SBOX = {
    128'h52096ad53036a538bf40a39e81f3d7fb,
    128'h7ce339829b2fff87348e4344c4dee9cb,
    128'h547b9432a6c2233dee4c950b42fac34e,
    128'h082ea16628d924b2765ba2496d8bd125,
    128'h72f8f66486689816d4a45ccc5d65b692,
    128'h6c704850fdedb9da5e154657a78d9d84,
    128'h90d8ab008cbcd30af7e45805b8b34506,
    128'hd02c1e8fca3f0f02c1afbd0301138a6b,
    128'h3a9111414f67dcea97f2cfcef0b4e673,
    128'h96ac7422e7ad3585e2f937e81c75df6e,
    128'h47f11a711d29c5896fb7620eaa18be1b,
    128'hfc563e4bc6d279209adbc0fe78cd5af4,
    128'h1fdda8338807c731b11210592780ec5f,
    128'h60517fa919b54a0d2de57a9f93c99cef,
    128'ha0e03b4dae2af5b0c8ebbb3c83539961,
    128'h172b047eba77d626e169146355210c7d
  };

  function automatic aes_byte_t aes_sbox(input aes_byte_t b);
    return AES_SBOX[b];
  endfunction

  function automatic aes_byte_t aes_inv_sbox(input aes_byte_t b);
    return AES_INV_SBOX[b];
  endfunction

  // ====================
  // GF(2^8) arithmetic
  // ====================

  // Multiply by x, reduce by the AES polynomial
  function automatic aes_byte_t aes_gmul2(input aes_byte_t b);
    return {b[`AES_BYTE_W-2:0], 1'b0} ^ (b[`AES_BYTE_W-1] ? 8'h1b : 8'h00);
  endfunction

  function automatic aes_byte_t aes_gmul9(input aes_byte_t b);
    aes_byte_t b8;
    b8 = aes_gmul2(aes_gmul2(aes_gmul2(b)));
    return b8 ^ b;
  endfunction

  function automatic aes_byte_t aes_gmul11(input aes_byte_t b);
    aes_byte_t b2;
    aes_byte_t b8;
    b2 = aes_gmul2(b);
    b8 = aes_gmul2(aes_gmul2(b2));
    return b8 ^ b2 ^ b;
  endfunction

  function automatic aes_byte_t aes_gmul13(input aes_byte_t b);
    aes_byte_t b4;
    aes_byte_t b8;
    b4 = aes_gmul2(aes_gmul2(b));
    b8 = aes_gmul2(b4);
    return b8 ^ b4 ^ b;
  endfunction

  function automatic aes_byte_t aes_gmul14(input aes_byte_t b);
    aes_byte_t b2;
    aes_byte_t b4;
    aes_byte_t b8;
    b2 = aes_gmul2(b);
    b4 = aes_gmul2(b2);
    b8 = aes_gmul2(b4);
    return b8 ^ b4 ^ b2;
  endfunction

  // Round constant is x^(round-1), so 01 for round 1 up to 36 for round 10
  function automatic aes_byte_t aes_rcon(input aes_round_t round);
    aes_byte_t rc;
    rc = 8'h01;
    for (int i = 1; i < `AES_NUM_ROUNDS; i++) begin
      if (i < round) begin
        rc = aes_gmul2(rc);
      end
    end
    return rc;
  endfunction

endpackage

// File: design/aes_config.svh
`ifndef AES_CONFIG_SVH
`define AES_CONFIG_SVH

// Block and key geometry
`define AES_BLOCK_W 128
`define AES_KEY_W 128

// AES-128 uses ten rounds after the initial whitening
`define AES_NUM_ROUNDS 10

// Sub-block widths
`define AES_WORD_W 32
`define AES_BYTE_W 8

// Start sample to done, in clock cycles
// One capture cycle, one whitening cycle, ten rounds
`define AES_DEC_LATENCY 12

`endif
